//--- design/rv_core_pkg.sv
// RV32I word-subset core definitions
// Widths, opcodes, funct3 codes and the ALU and writeback select types
package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    // Opcodes kept in the subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD = 3'b000;  // Also SUB, told apart by funct7[5]
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_LW  = 3'b010;  // SW uses the same code

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_t;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } wb_sel_t;

endpackage

//--- design/fetch_stage.sv
// Fetch stage
// PC, instruction memory with a load port, and the IF/ID register
`timescale 1ns/100ps

module fetch_stage #(
    parameter int IMEM_ADDR_W = 8
) (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic                         i_en,
    input  logic                         i_stall,
    input  logic                         i_imem_wen,
    input  logic [IMEM_ADDR_W-1:0]       i_imem_waddr,
    input  logic [rv_core_pkg::XLEN-1:0] i_imem_data,
    output logic [rv_core_pkg::XLEN-1:0] o_pc,
    output logic [rv_core_pkg::XLEN-1:0] o_id_pc,
    output logic [rv_core_pkg::XLEN-1:0] o_id_instr
);

    logic [rv_core_pkg::XLEN-1:0] imem [2**IMEM_ADDR_W];
    logic [rv_core_pkg::XLEN-1:0] fetch_instr;

    // Load port, used while the core is halted
    always_ff @(posedge clk) begin
        if (i_imem_wen) begin
            imem[i_imem_waddr] <= i_imem_data;
        end
    end

    assign fetch_instr = imem[o_pc[IMEM_ADDR_W+1:2]];  // Word index of the PC

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_pc       <= '0;
            o_id_pc    <= '0;
            o_id_instr <= rv_core_pkg::NOP_INSTR;
        end else if (i_en && !i_stall) begin
            o_pc       <= o_pc + 32'd4;
            o_id_pc    <= o_pc;
            o_id_instr <= fetch_instr;
        end
    end

    // A load while running would race the fetch read
    a_load_halted: assert property (
        @(posedge clk) disable iff (i_rst) i_imem_wen |-> !i_en
    ) else $error("fetch_stage: instruction memory written while running");

endmodule

//--- design/reg_file.sv
// Integer register file, 32 x XLEN
// Two pipeline read ports with write-through and a registered debug port
`timescale 1ns/100ps

module reg_file (
    input  logic                               clk,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_rs2_addr,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_wb_rd,
    input  logic                               i_wb_we,
    input  logic [rv_core_pkg::XLEN-1:0]       i_wb_data,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_dbg_addr,
    output logic [rv_core_pkg::XLEN-1:0]       o_rs1_data,
    output logic [rv_core_pkg::XLEN-1:0]       o_rs2_data,
    output logic [rv_core_pkg::XLEN-1:0]       o_dbg_data
);

    logic [rv_core_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (i_wb_we && i_wb_rd != '0) begin  // x0 stays hardwired
            regs[i_wb_rd] <= i_wb_data;
        end
        o_dbg_data <= (i_dbg_addr == '0) ? '0 : regs[i_dbg_addr];
    end

    // Same-cycle write bypasses the array
    assign o_rs1_data = (i_rs1_addr == '0)                       ? '0        :
                        (i_wb_we && i_wb_rd == i_rs1_addr)       ? i_wb_data :
                                                                   regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0)                       ? '0        :
                        (i_wb_we && i_wb_rd == i_rs2_addr)       ? i_wb_data :
                                                                   regs[i_rs2_addr];

    // Decode drops reg_we for rd x0, so writeback never targets it
    a_no_x0_write: assert property (
        @(posedge clk) i_wb_we |-> i_wb_rd != '0
    ) else $error("reg_file: write to x0 reached writeback");

endmodule

//--- design/decode_stage.sv
// Decode stage
// Control decode, immediates, load-use hazard detection and ID/EX register
`timescale 1ns/100ps

module decode_stage (
    input  logic                               clk,
    input  logic                               i_rst,
    input  logic                               i_en,
    input  logic [rv_core_pkg::XLEN-1:0]       i_id_pc,
    input  logic [rv_core_pkg::XLEN-1:0]       i_id_instr,
    input  logic [rv_core_pkg::XLEN-1:0]       i_rs1_data,
    input  logic [rv_core_pkg::XLEN-1:0]       i_rs2_data,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_rs1_addr,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_rs2_addr,
    output logic                               o_stall,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_ex_rs1_addr,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_ex_rs2_addr,
    output logic [rv_core_pkg::XLEN-1:0]       o_ex_rs1_data,
    output logic [rv_core_pkg::XLEN-1:0]       o_ex_rs2_data,
    output logic [rv_core_pkg::XLEN-1:0]       o_ex_imm,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_ex_rd,
    output logic                               o_ex_reg_we,
    output logic                               o_ex_mem_we,
    output logic                               o_ex_use_imm,
    output rv_core_pkg::wb_sel_t               o_ex_wb_sel,
    output rv_core_pkg::alu_op_t               o_ex_alu_op
);

    logic [6:0]                         opcode;
    logic [2:0]                         funct3;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rd;
    logic                               f3_valid;
    logic                               uses_rs1;
    logic                               uses_rs2;
    logic                               reg_we;
    logic                               mem_we;
    logic                               use_imm;
    logic                               is_store;
    rv_core_pkg::wb_sel_t               wb_sel;
    rv_core_pkg::alu_op_t               alu_op;
    logic                               ex_is_load;

    assign opcode     = i_id_instr[6:0];
    assign funct3     = i_id_instr[14:12];
    assign rd         = i_id_instr[11:7];
    assign o_rs1_addr = i_id_instr[19:15];
    assign o_rs2_addr = i_id_instr[24:20];

    always_comb begin
        f3_valid = 1'b1;
        case (funct3)
            rv_core_pkg::F3_ADD: alu_op = (opcode == rv_core_pkg::OPC_OP && i_id_instr[30]) ?
                                          rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            rv_core_pkg::F3_SLT: alu_op = rv_core_pkg::ALU_SLT;
            rv_core_pkg::F3_XOR: alu_op = rv_core_pkg::ALU_XOR;
            rv_core_pkg::F3_OR:  alu_op = rv_core_pkg::ALU_OR;
            rv_core_pkg::F3_AND: alu_op = rv_core_pkg::ALU_AND;
            default: begin
                alu_op   = rv_core_pkg::ALU_ADD;
                f3_valid = 1'b0;
            end
        endcase

        uses_rs1 = 1'b0;  // Anything unknown falls through as a NOP
        uses_rs2 = 1'b0;
        reg_we   = 1'b0;
        mem_we   = 1'b0;
        use_imm  = 1'b0;
        wb_sel   = rv_core_pkg::WB_ALU;
        if (opcode == rv_core_pkg::OPC_OP && f3_valid) begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            reg_we   = 1'b1;
        end else if (opcode == rv_core_pkg::OPC_OP_IMM && f3_valid) begin
            uses_rs1 = 1'b1;
            reg_we   = 1'b1;
            use_imm  = 1'b1;
        end else if (opcode == rv_core_pkg::OPC_LOAD && funct3 == rv_core_pkg::F3_LW) begin
            uses_rs1 = 1'b1;
            reg_we   = 1'b1;
            use_imm  = 1'b1;
            wb_sel   = rv_core_pkg::WB_MEM;
            alu_op   = rv_core_pkg::ALU_ADD;  // Address add
        end else if (opcode == rv_core_pkg::OPC_STORE && funct3 == rv_core_pkg::F3_LW) begin
            uses_rs1 = 1'b1;
            uses_rs2 = 1'b1;
            mem_we   = 1'b1;
            use_imm  = 1'b1;
            alu_op   = rv_core_pkg::ALU_ADD;
        end
        reg_we = reg_we && rd != '0;
    end

    assign is_store = (opcode == rv_core_pkg::OPC_STORE);

    // Load in ID/EX whose rd is a source here; reg_we already implies rd != x0
    assign ex_is_load = o_ex_reg_we && o_ex_wb_sel == rv_core_pkg::WB_MEM;
    assign o_stall    = ex_is_load && ((uses_rs1 && o_rs1_addr == o_ex_rd) ||
                                       (uses_rs2 && o_rs2_addr == o_ex_rd));

    // Control half of ID/EX; a stall pushes a bubble with no sources
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ex_rs1_addr <= '0;
            o_ex_rs2_addr <= '0;
            o_ex_reg_we   <= 1'b0;
            o_ex_mem_we   <= 1'b0;
            o_ex_use_imm  <= 1'b0;
            o_ex_wb_sel   <= rv_core_pkg::WB_ALU;
            o_ex_alu_op   <= rv_core_pkg::ALU_ADD;
        end else if (i_en) begin
            o_ex_rs1_addr <= (uses_rs1 && !o_stall) ? o_rs1_addr : '0;
            o_ex_rs2_addr <= (uses_rs2 && !o_stall) ? o_rs2_addr : '0;
            o_ex_reg_we   <= reg_we && !o_stall;
            o_ex_mem_we   <= mem_we && !o_stall;
            o_ex_use_imm  <= use_imm;
            o_ex_wb_sel   <= wb_sel;
            o_ex_alu_op   <= alu_op;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_ex_rs1_data <= i_rs1_data;
            o_ex_rs2_data <= i_rs2_data;
            o_ex_rd       <= rd;
            o_ex_imm      <= is_store ? {{20{i_id_instr[31]}}, i_id_instr[31:25], i_id_instr[11:7]}
                                      : {{20{i_id_instr[31]}}, i_id_instr[31:20]};
        end
    end

    // Fetch must hold IF/ID across the stalled edge
    a_ifid_held: assert property (
        @(posedge clk) disable iff (i_rst) (i_en && o_stall) |=> $stable(i_id_pc)
    ) else $error("decode_stage: IF/ID advanced during a stall");

endmodule

//--- design/execute_stage.sv
// Execute stage
// Forwarding, operand select, ALU and the EX/MEM register
`timescale 1ns/100ps

module execute_stage (
    input  logic                               clk,
    input  logic                               i_rst,
    input  logic                               i_en,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_ex_rs1_addr,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_ex_rs2_addr,
    input  logic [rv_core_pkg::XLEN-1:0]       i_ex_rs1_data,
    input  logic [rv_core_pkg::XLEN-1:0]       i_ex_rs2_data,
    input  logic [rv_core_pkg::XLEN-1:0]       i_ex_imm,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_ex_rd,
    input  logic                               i_ex_reg_we,
    input  logic                               i_ex_mem_we,
    input  logic                               i_ex_use_imm,
    input  rv_core_pkg::wb_sel_t               i_ex_wb_sel,
    input  rv_core_pkg::alu_op_t               i_ex_alu_op,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_wb_rd,
    input  logic                               i_wb_we,
    input  logic [rv_core_pkg::XLEN-1:0]       i_wb_data,
    output logic [rv_core_pkg::XLEN-1:0]       o_mem_alu,
    output logic [rv_core_pkg::XLEN-1:0]       o_mem_store_data,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_mem_rd,
    output logic                               o_mem_reg_we,
    output logic                               o_mem_mem_we,
    output rv_core_pkg::wb_sel_t               o_mem_wb_sel
);

    logic                         mem_fwd_ok;
    logic                         mem_is_load;
    logic [rv_core_pkg::XLEN-1:0] src_a;
    logic [rv_core_pkg::XLEN-1:0] src_b;
    logic [rv_core_pkg::XLEN-1:0] alu_b;
    logic [rv_core_pkg::XLEN-1:0] alu_res;

    assign mem_is_load = o_mem_reg_we && o_mem_wb_sel == rv_core_pkg::WB_MEM;
    assign mem_fwd_ok  = o_mem_reg_we && !mem_is_load;  // Load data not ready yet

    // EX/MEM wins over writeback, being the younger result
    always_comb begin
        if (mem_fwd_ok && o_mem_rd == i_ex_rs1_addr)
            src_a = o_mem_alu;
        else if (i_wb_we && i_wb_rd == i_ex_rs1_addr)
            src_a = i_wb_data;
        else
            src_a = i_ex_rs1_data;

        if (mem_fwd_ok && o_mem_rd == i_ex_rs2_addr)
            src_b = o_mem_alu;
        else if (i_wb_we && i_wb_rd == i_ex_rs2_addr)
            src_b = i_wb_data;
        else
            src_b = i_ex_rs2_data;
    end

    assign alu_b = i_ex_use_imm ? i_ex_imm : src_b;

    always_comb begin
        case (i_ex_alu_op)
            rv_core_pkg::ALU_SUB: alu_res = src_a - alu_b;
            rv_core_pkg::ALU_AND: alu_res = src_a & alu_b;
            rv_core_pkg::ALU_OR:  alu_res = src_a | alu_b;
            rv_core_pkg::ALU_XOR: alu_res = src_a ^ alu_b;
            rv_core_pkg::ALU_SLT: alu_res = {31'd0, $signed(src_a) < $signed(alu_b)};
            default:              alu_res = src_a + alu_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_mem_reg_we <= 1'b0;
            o_mem_mem_we <= 1'b0;
            o_mem_wb_sel <= rv_core_pkg::WB_ALU;
        end else if (i_en) begin
            o_mem_reg_we <= i_ex_reg_we;
            o_mem_mem_we <= i_ex_mem_we;
            o_mem_wb_sel <= i_ex_wb_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_mem_alu        <= alu_res;
            o_mem_store_data <= src_b;  // Forwarded rs2
            o_mem_rd         <= i_ex_rd;
        end
    end

    // Decode's stall must keep a load's user out of EX for one cycle
    a_no_load_fwd: assert property (
        @(posedge clk) disable iff (i_rst)
        mem_is_load |-> (o_mem_rd != i_ex_rs1_addr && o_mem_rd != i_ex_rs2_addr)
    ) else $error("execute_stage: load result needed before it exists");

endmodule

//--- design/memory_stage.sv
// Memory stage
// Word data memory with debug read port, MEM/WB register and writeback select
`timescale 1ns/100ps

module memory_stage #(
    parameter int DMEM_ADDR_W = 5
) (
    input  logic                               clk,
    input  logic                               i_rst,
    input  logic                               i_en,
    input  logic [rv_core_pkg::XLEN-1:0]       i_mem_alu,
    input  logic [rv_core_pkg::XLEN-1:0]       i_mem_store_data,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_mem_rd,
    input  logic                               i_mem_reg_we,
    input  logic                               i_mem_mem_we,
    input  rv_core_pkg::wb_sel_t               i_mem_wb_sel,
    input  logic [DMEM_ADDR_W-1:0]             i_dbg_addr,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic                               o_wb_we,
    output logic [rv_core_pkg::XLEN-1:0]       o_wb_data,
    output logic [rv_core_pkg::XLEN-1:0]       o_dbg_data
);

    logic [rv_core_pkg::XLEN-1:0] dmem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0]       word_addr;
    logic                         wb_we_q;
    rv_core_pkg::wb_sel_t         wb_sel_q;
    logic [rv_core_pkg::XLEN-1:0] alu_q;
    logic [rv_core_pkg::XLEN-1:0] load_q;

    assign word_addr = i_mem_alu[DMEM_ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (i_mem_mem_we && i_en) begin
            dmem[word_addr] <= i_mem_store_data;
        end
        o_dbg_data <= dmem[i_dbg_addr];  // Runs even when halted
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wb_we_q  <= 1'b0;
            wb_sel_q <= rv_core_pkg::WB_ALU;
        end else if (i_en) begin
            wb_we_q  <= i_mem_reg_we;
            wb_sel_q <= i_mem_wb_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_wb_rd <= i_mem_rd;
            alu_q   <= i_mem_alu;
            load_q  <= dmem[word_addr];
        end
    end

    assign o_wb_we   = wb_we_q && i_en;  // Register file write holds while halted
    assign o_wb_data = (wb_sel_q == rv_core_pkg::WB_MEM) ? load_q : alu_q;

endmodule

//--- design/cpu_core.sv
// Five-stage RV32I word-subset core
// Chains fetch, decode, execute and memory stages around the register file
`timescale 1ns/100ps

module cpu_core #(
    parameter int IMEM_ADDR_W = 8,
    parameter int DMEM_ADDR_W = 5
) (
    input  logic                               clk,
    input  logic                               i_rst,
    input  logic                               i_en,
    input  logic                               i_imem_wen,
    input  logic [IMEM_ADDR_W-1:0]             i_imem_waddr,
    input  logic [rv_core_pkg::XLEN-1:0]       i_imem_data,
    input  logic [rv_core_pkg::REG_ADDR_W-1:0] i_dbg_reg_addr,
    input  logic [DMEM_ADDR_W-1:0]             i_dbg_mem_addr,
    output logic [rv_core_pkg::XLEN-1:0]       o_pc,
    output logic [rv_core_pkg::XLEN-1:0]       o_dbg_reg_data,
    output logic [rv_core_pkg::XLEN-1:0]       o_dbg_mem_data
);

    // IF/ID and register file reads
    logic [rv_core_pkg::XLEN-1:0]       id_pc, id_instr, rs1_data, rs2_data;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic                               stall;
    // ID/EX
    logic [rv_core_pkg::REG_ADDR_W-1:0] ex_rs1_addr, ex_rs2_addr, ex_rd;
    logic [rv_core_pkg::XLEN-1:0]       ex_rs1_data, ex_rs2_data, ex_imm;
    logic                               ex_reg_we, ex_mem_we, ex_use_imm;
    rv_core_pkg::wb_sel_t               ex_wb_sel;
    rv_core_pkg::alu_op_t               ex_alu_op;
    // EX/MEM
    logic [rv_core_pkg::XLEN-1:0]       mem_alu, mem_store_data;
    logic [rv_core_pkg::REG_ADDR_W-1:0] mem_rd;
    logic                               mem_reg_we, mem_mem_we;
    rv_core_pkg::wb_sel_t               mem_wb_sel;
    // Writeback
    logic [rv_core_pkg::REG_ADDR_W-1:0] wb_rd;
    logic                               wb_we;
    logic [rv_core_pkg::XLEN-1:0]       wb_data;

    fetch_stage #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_fetch (
        .clk(clk), .i_rst(i_rst), .i_en(i_en), .i_stall(stall),
        .i_imem_wen(i_imem_wen), .i_imem_waddr(i_imem_waddr), .i_imem_data(i_imem_data),
        .o_pc(o_pc), .o_id_pc(id_pc), .o_id_instr(id_instr)
    );

    reg_file u_reg_file (
        .clk(clk), .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
        .i_wb_rd(wb_rd), .i_wb_we(wb_we), .i_wb_data(wb_data), .i_dbg_addr(i_dbg_reg_addr),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .o_dbg_data(o_dbg_reg_data)
    );

    decode_stage u_decode (
        .clk(clk), .i_rst(i_rst), .i_en(i_en), .i_id_pc(id_pc), .i_id_instr(id_instr),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_stall(stall),
        .o_ex_rs1_addr(ex_rs1_addr), .o_ex_rs2_addr(ex_rs2_addr),
        .o_ex_rs1_data(ex_rs1_data), .o_ex_rs2_data(ex_rs2_data), .o_ex_imm(ex_imm),
        .o_ex_rd(ex_rd), .o_ex_reg_we(ex_reg_we), .o_ex_mem_we(ex_mem_we),
        .o_ex_use_imm(ex_use_imm), .o_ex_wb_sel(ex_wb_sel), .o_ex_alu_op(ex_alu_op)
    );

    execute_stage u_execute (
        .clk(clk), .i_rst(i_rst), .i_en(i_en),
        .i_ex_rs1_addr(ex_rs1_addr), .i_ex_rs2_addr(ex_rs2_addr),
        .i_ex_rs1_data(ex_rs1_data), .i_ex_rs2_data(ex_rs2_data), .i_ex_imm(ex_imm),
        .i_ex_rd(ex_rd), .i_ex_reg_we(ex_reg_we), .i_ex_mem_we(ex_mem_we),
        .i_ex_use_imm(ex_use_imm), .i_ex_wb_sel(ex_wb_sel), .i_ex_alu_op(ex_alu_op),
        .i_wb_rd(wb_rd), .i_wb_we(wb_we), .i_wb_data(wb_data),
        .o_mem_alu(mem_alu), .o_mem_store_data(mem_store_data), .o_mem_rd(mem_rd),
        .o_mem_reg_we(mem_reg_we), .o_mem_mem_we(mem_mem_we), .o_mem_wb_sel(mem_wb_sel)
    );

    memory_stage #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_memory (
        .clk(clk), .i_rst(i_rst), .i_en(i_en),
        .i_mem_alu(mem_alu), .i_mem_store_data(mem_store_data), .i_mem_rd(mem_rd),
        .i_mem_reg_we(mem_reg_we), .i_mem_mem_we(mem_mem_we), .i_mem_wb_sel(mem_wb_sel),
        .i_dbg_addr(i_dbg_mem_addr),
        .o_wb_rd(wb_rd), .o_wb_we(wb_we), .o_wb_data(wb_data), .o_dbg_data(o_dbg_mem_data)
    );

endmodule

//--- verif/tb_cpu_core.sv
// Testbench for the five-stage RV32I word-subset core
// Random program run against an instruction-level model, checked over debug ports
`timescale 1ns/100ps

module tb_cpu_core;

    localparam int IMEM_ADDR_W = 8;
    localparam int DMEM_ADDR_W = 5;
    localparam int DMEM_WORDS  = 2**DMEM_ADDR_W;
    localparam int PROG_LEN    = 48;
    localparam int PAD_LEN     = 8;
    localparam int TAIL_LEN    = 8;
    localparam int RUN_TIMEOUT = 400;  // Cycles

    // Instruction kinds of the generator
    localparam logic [1:0] K_R  = 2'd0;
    localparam logic [1:0] K_I  = 2'd1;
    localparam logic [1:0] K_LW = 2'd2;
    localparam logic [1:0] K_SW = 2'd3;

    logic                   clk;
    logic                   i_rst;
    logic                   i_en;
    logic                   i_imem_wen;
    logic [IMEM_ADDR_W-1:0] i_imem_waddr;
    logic [31:0]            i_imem_data;
    logic [4:0]             i_dbg_reg_addr;
    logic [DMEM_ADDR_W-1:0] i_dbg_mem_addr;
    logic [31:0]            o_pc;
    logic [31:0]            o_dbg_reg_data;
    logic [31:0]            o_dbg_mem_data;

    logic [31:0] seed;
    logic [31:0] prog [2**IMEM_ADDR_W];
    logic [31:0] model_regs [8];
    logic [31:0] model_mem [DMEM_WORDS];
    logic        mem_written [DMEM_WORDS];
    logic [31:0] snap_regs [2][8];  // Debug sweeps before and after the halt window
    logic [31:0] snap_mem [2][DMEM_WORDS];
    int          errors;
    int          exp_stalls;
    int          seen_stalls;

    cpu_core #(.IMEM_ADDR_W(IMEM_ADDR_W), .DMEM_ADDR_W(DMEM_ADDR_W)) UUT (
        .clk(clk), .i_rst(i_rst), .i_en(i_en),
        .i_imem_wen(i_imem_wen), .i_imem_waddr(i_imem_waddr), .i_imem_data(i_imem_data),
        .i_dbg_reg_addr(i_dbg_reg_addr), .i_dbg_mem_addr(i_dbg_mem_addr),
        .o_pc(o_pc), .o_dbg_reg_data(o_dbg_reg_data), .o_dbg_mem_data(o_dbg_mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw(input logic [31:0] limit, output logic [31:0] val);
        seed = lcg_next(seed);
        val  = {16'd0, seed[31:16]} % limit;  // Upper bits are the better ones
    endtask

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Generator op codes: 0 ADD, 1 SUB, 2 AND, 3 OR, 4 XOR, 5 SLT
    function automatic logic [2:0] alu_funct3(input logic [2:0] aop);
        case (aop)
            3'd2:    return rv_core_pkg::F3_AND;
            3'd3:    return rv_core_pkg::F3_OR;
            3'd4:    return rv_core_pkg::F3_XOR;
            3'd5:    return rv_core_pkg::F3_SLT;
            default: return rv_core_pkg::F3_ADD;
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] aop, input logic [31:0] a,
                                            input logic [31:0] b);
        case (aop)
            3'd1:    return a - b;
            3'd2:    return a & b;
            3'd3:    return a | b;
            3'd4:    return a ^ b;
            3'd5:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a + b;
        endcase
    endfunction

    function automatic logic [31:0] encode_r(input logic [2:0] aop, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        logic [6:0] f7;
        f7 = (aop == 3'd1) ? 7'b0100000 : 7'b0000000;  // SUB flag
        return {f7, rs2, rs1, alu_funct3(aop), rd, rv_core_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] encode_i(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encode_s(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, rv_core_pkg::F3_LW, imm[4:0], rv_core_pkg::OPC_STORE};
    endfunction

    // Generates one instruction at a time and steps the model over it
    task automatic build_program();
        logic [31:0]            v;
        logic [31:0]            res;
        logic [1:0]             kind;
        logic [2:0]             aop;
        logic [4:0]             rd, rs1, rs2, use1, use2, prev_load_rd;
        logic [11:0]            imm;
        logic [DMEM_ADDR_W-1:0] w;
        logic [DMEM_ADDR_W-1:0] stored_q[$];
        prev_load_rd = '0;
        exp_stalls   = 0;
        w            = '0;
        for (int i = 0; i < 8; i++)
            model_regs[3'(i)] = '0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            model_mem[DMEM_ADDR_W'(i)]   = '0;
            mem_written[DMEM_ADDR_W'(i)] = 1'b0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            draw(8, v);
            rd = 5'(v);
            draw(8, v);
            rs1 = 5'(v);
            draw(8, v);
            rs2 = 5'(v);
            draw(4096, v);
            imm = 12'(v);
            draw(2, v);
            if (prev_load_rd != '0 && v[0]) begin  // Put a user right behind the load
                rs1 = prev_load_rd;
                rs2 = prev_load_rd;
            end
            draw(16, v);
            aop = 3'd0;
            if (i < 7) begin
                kind = K_I;  // Seed x1..x7 before anything reads them
                rd   = 5'(i + 1);
                rs1  = '0;
            end else if (v < 5) begin
                kind = K_R;
                draw(6, v);
                aop = 3'(v);
            end else if (v < 10) begin
                kind = K_I;
                draw(5, v);
                aop = (v == 1) ? 3'd5 : 3'(v);  // There is no SUBI
            end else if (v < 13 && stored_q.size() > 0) begin
                kind = K_LW;
                draw(stored_q.size(), v);  // Only words already stored
                w = stored_q[v];
            end else begin
                kind = K_SW;
                draw(DMEM_WORDS, v);
                w = DMEM_ADDR_W'(v);
            end
            if (kind == K_LW || kind == K_SW) begin
                rs1 = '0;
                imm = 12'({w, 2'b00});
            end
            use1 = (kind == K_R || kind == K_I) ? rs1 : '0;
            use2 = (kind == K_R || kind == K_SW) ? rs2 : '0;
            if (prev_load_rd != '0 && (use1 == prev_load_rd || use2 == prev_load_rd))
                exp_stalls++;
            case (kind)
                K_R: begin
                    prog[IMEM_ADDR_W'(i)] = encode_r(aop, rd, rs1, rs2);
                    res = alu_ref(aop, model_regs[rs1[2:0]], model_regs[rs2[2:0]]);
                end
                K_I: begin
                    prog[IMEM_ADDR_W'(i)] = encode_i(alu_funct3(aop), rd, rs1, imm,
                                                     rv_core_pkg::OPC_OP_IMM);
                    res = alu_ref(aop, model_regs[rs1[2:0]], {{20{imm[11]}}, imm});
                end
                K_LW: begin
                    prog[IMEM_ADDR_W'(i)] = encode_i(rv_core_pkg::F3_LW, rd, rs1, imm,
                                                     rv_core_pkg::OPC_LOAD);
                    res = model_mem[w];
                end
                default: begin
                    prog[IMEM_ADDR_W'(i)] = encode_s(rs2, rs1, imm);
                    res = '0;
                    model_mem[w] = model_regs[rs2[2:0]];
                    if (!mem_written[w])
                        stored_q.push_back(w);
                    mem_written[w] = 1'b1;
                end
            endcase
            if (kind != K_SW && rd != '0)
                model_regs[rd[2:0]] = res;  // x0 keeps zero
            prev_load_rd = (kind == K_LW) ? rd : '0;
        end
        for (int i = PROG_LEN; i < PROG_LEN + PAD_LEN; i++)
            prog[IMEM_ADDR_W'(i)] = rv_core_pkg::NOP_INSTR;
        // Live words past the padding, they retire only if the halt lets the core run
        for (int i = PROG_LEN + PAD_LEN; i < PROG_LEN + PAD_LEN + TAIL_LEN; i++) begin
            if (i % 2 == 0)
                prog[IMEM_ADDR_W'(i)] = encode_i(rv_core_pkg::F3_ADD, 5'(i % 7 + 1),
                                                 5'(i % 7 + 1), 12'(i),
                                                 rv_core_pkg::OPC_OP_IMM);
            else
                prog[IMEM_ADDR_W'(i)] = encode_s(5'(i % 7 + 1), 5'd0,
                                                 12'(4 * (i % DMEM_WORDS)));
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_LEN + PAD_LEN + TAIL_LEN; i++) begin
            @(posedge clk);
            i_imem_wen   <= 1'b1;
            i_imem_waddr <= IMEM_ADDR_W'(i);
            i_imem_data  <= prog[IMEM_ADDR_W'(i)];
        end
        @(posedge clk);
        i_imem_wen <= 1'b0;
    endtask

    // Runs until the PC passes the padding, counting cycles where it held
    task automatic run_program(output bit done);
        logic [31:0] prev_pc;
        int          cycles;
        done   = 1'b0;
        cycles = 0;
        @(posedge clk);
        i_en <= 1'b1;
        @(negedge clk);
        prev_pc = o_pc;
        while (!done && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (o_pc == prev_pc)
                seen_stalls++;
            prev_pc = o_pc;
            if (o_pc >= 32'((PROG_LEN + PAD_LEN) * 4))
                done = 1'b1;
        end
        @(posedge clk);
        i_en <= 1'b0;
    endtask

    // Debug data is valid one clock after the address
    task automatic sweep_debug(input bit slot);
        for (int a = 0; a < DMEM_WORDS; a++) begin
            @(posedge clk);
            i_dbg_reg_addr <= 5'(a);
            i_dbg_mem_addr <= DMEM_ADDR_W'(a);
            @(posedge clk);
            @(negedge clk);
            if (a < 8)
                snap_regs[slot][3'(a)] = o_dbg_reg_data;
            snap_mem[slot][DMEM_ADDR_W'(a)] = o_dbg_mem_data;
        end
    endtask

    task automatic check_halt();
        logic [31:0] held_pc;
        @(negedge clk);
        held_pc = o_pc;
        repeat (10) begin
            @(negedge clk);
            compare_word("pc while halted", o_pc, held_pc);
        end
    endtask

    task automatic check_state();
        for (int a = 0; a < 8; a++) begin
            compare_word($sformatf("x%0d across halt", a), snap_regs[1][3'(a)],
                         snap_regs[0][3'(a)]);
            compare_word($sformatf("x%0d", a), snap_regs[0][3'(a)], model_regs[3'(a)]);
        end
        for (int a = 0; a < DMEM_WORDS; a++) begin
            compare_word($sformatf("dmem[%0d] across halt", a),
                         snap_mem[1][DMEM_ADDR_W'(a)], snap_mem[0][DMEM_ADDR_W'(a)]);
            if (mem_written[DMEM_ADDR_W'(a)])
                compare_word($sformatf("dmem[%0d]", a), snap_mem[0][DMEM_ADDR_W'(a)],
                             model_mem[DMEM_ADDR_W'(a)]);
        end
    endtask

    initial begin
        bit done;
        i_rst          <= 1'b1;
        i_en           <= 1'b0;
        i_imem_wen     <= 1'b0;
        i_imem_waddr   <= '0;
        i_imem_data    <= '0;
        i_dbg_reg_addr <= '0;
        i_dbg_mem_addr <= '0;
        seed        = 32'hbd4c;
        errors      = 0;
        seen_stalls = 0;
        build_program();
        repeat (2) @(posedge clk);
        i_rst <= 1'b0;
        load_program();
        run_program(done);
        if (!done) begin
            errors++;
            $display("timeout: the PC never passed the end of the program");
        end else begin
            compare_word("load-use stall count", 32'(seen_stalls), 32'(exp_stalls));
            sweep_debug(1'b0);
            check_halt();
            sweep_debug(1'b1);
            check_state();
        end
        $display("errors: %0d, load-use stalls seen: %0d", errors, seen_stalls);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- verilog.f
design/rv_core_pkg.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu_core.sv
verif/tb_cpu_core.sv

//--- Makefile
# Verilator build and run of the RV32I word-subset core testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_cpu_core -Mdir obj_dir -f verilog.f
	./obj_dir/Vtb_cpu_core > sim.log 2>&1; cat sim.log
	@if grep -q "tests failed" sim.log || ! grep -q "all tests passed" sim.log; then \
		echo "simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
